//--- src/zmips_pkg.sv
// Shared definitions for the zmips core
// ISA field widths, format and branch condition codes
// ALU operation codes and the instruction word union
`default_nettype none

package zmips_pkg;

    localparam int XLEN     = 32;   // Word width
    localparam int REG_AW   = 5;    // Register index width
    localparam int NUM_REGS = 32;
    localparam int IMM_W    = 26;   // I-format immediate width
    localparam int PC_STEP  = 4;    // One word per fetch

    // Instruction bits 31:30, values 0x are R-format (incl. immediate load)
    localparam logic [1:0] FMT_I = 2'b10;
    localparam logic [1:0] FMT_J = 2'b11;

    // Branch condition codes
    localparam logic [1:0] CC_Z      = 2'd0;
    localparam logic [1:0] CC_C      = 2'd1;
    localparam logic [1:0] CC_N      = 2'd2;
    localparam logic [1:0] CC_ALWAYS = 2'd3;

    localparam logic [XLEN-1:0] NOP_WORD = '0;

    typedef logic [3:0] alu_op_t;

    // Bit 3 selects the shifter, low bits come from funct[5:3]
    localparam alu_op_t ALU_PASS = 4'b0000;
    localparam alu_op_t ALU_AND  = 4'b0001;
    localparam alu_op_t ALU_OR   = 4'b0010;
    localparam alu_op_t ALU_XOR  = 4'b0011;
    localparam alu_op_t ALU_ADD  = 4'b0100;
    localparam alu_op_t ALU_SUB  = 4'b0101;
    localparam alu_op_t ALU_SLL  = 4'b1000;
    localparam alu_op_t ALU_SRL  = 4'b1010;
    localparam alu_op_t ALU_SRA  = 4'b1011;

    // One instruction word seen as each of the three formats
    typedef union packed {
        struct packed {
            logic [5:0]        op;      // 26 = shift, 28 = write, 29 = store, 30 = imm load
            logic [REG_AW-1:0] rs;
            logic [REG_AW-1:0] rt;
            logic [REG_AW-1:0] rd;
            logic [REG_AW-1:0] shamt;
            logic [5:0]        funct;   // 5:3 ALU code, 2:0 N/C/Z update enables
        } r_fmt;
        struct packed {
            logic [3:0]       op;       // Bit 29 selects branch on set
            logic [1:0]       cc;
            logic [IMM_W-1:0] imm;
        } i_fmt;
        struct packed {
            logic [1:0]      op;
            logic [XLEN-3:0] addr;      // Word address of the target
        } j_fmt;
    } instr_u;

endpackage

`default_nettype wire

//--- src/zmips_fetch.sv
// Instruction fetch stage
// Program counter with incrementer and redirect load
// IF/ID register, flushed to NOP behind a branch or jump
`default_nettype none

module zmips_fetch import zmips_pkg::*;
(
    input  logic            clk,
    input  logic            rst,
    input  logic            redirect,      // Load PC from ID
    input  logic [XLEN-1:0] redirect_pc,
    input  logic            squash,        // Replace fetched word with NOP
    input  logic [XLEN-1:0] i_data,
    output logic [XLEN-1:0] i_addr,
    output instr_u          id_instr,
    output logic [XLEN-1:0] id_pc
);

    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] pc_next;

    assign pc_next = redirect ? redirect_pc : pc + XLEN'(PC_STEP);
    assign i_addr  = pc;                    // Memory answers in the same cycle

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            pc       <= '0;
            id_instr <= NOP_WORD;
        end
        else
        begin
            pc       <= pc_next;
            id_instr <= squash ? NOP_WORD : i_data;    // No delay slot
        end
    end

    // Fetch address travels with the word, branch base in ID
    always_ff @(posedge clk)
    begin
        id_pc <= pc;
    end

endmodule

`default_nettype wire

//--- src/zmips_control.sv
// Central controller in the decode stage
// Format decode, branch decision on forwarded flags, redirect target
// ID/EX control register
`default_nettype none

module zmips_control import zmips_pkg::*;
(
    input  logic            clk,
    input  logic            rst,
    input  instr_u          id_instr,
    input  logic [XLEN-1:0] id_pc,
    input  logic            flag_z,
    input  logic            flag_c,
    input  logic            flag_n,
    input  logic            ex_z,          // Live ALU flags of the word in EX
    input  logic            ex_c,
    input  logic            ex_n,
    output logic            redirect,
    output logic [XLEN-1:0] redirect_pc,
    output logic            squash,
    output alu_op_t         ex_alu_op,
    output logic            ex_use_imm,
    output logic            ex_wr_reg,
    output logic            ex_store,
    output logic            ex_wr_z,
    output logic            ex_wr_c,
    output logic            ex_wr_n
);

    logic            is_r, is_i, is_j;
    logic            imm_load;
    logic            fz, fc, fn;           // Flags as seen by the branch
    logic            take;
    logic [XLEN-1:0] seq_pc;
    logic [XLEN-1:0] imm_se;
    logic [XLEN-1:0] br_pc;

    // Format from bits 31:30
    assign is_i     = (id_instr.j_fmt.op == FMT_I);
    assign is_j     = (id_instr.j_fmt.op == FMT_J);
    assign is_r     = ~id_instr.j_fmt.op[1];
    assign imm_load = is_r & id_instr.r_fmt.op[4];    // Bit 30

    // Take the EX result when that word updates the flag
    assign fz = ex_wr_z ? ex_z : flag_z;
    assign fc = ex_wr_c ? ex_c : flag_c;
    assign fn = ex_wr_n ? ex_n : flag_n;

    always_comb
    begin
        case (id_instr.i_fmt.cc)
            CC_Z:    take = (fz == id_instr.i_fmt.op[1]);     // Bit 29 is set/clear sense
            CC_C:    take = (fc == id_instr.i_fmt.op[1]);
            CC_N:    take = (fn == id_instr.i_fmt.op[1]);
            default: take = 1'b1;                             // CC_ALWAYS
        endcase
    end

    assign imm_se = {{(XLEN-IMM_W){id_instr.i_fmt.imm[IMM_W-1]}}, id_instr.i_fmt.imm};
    assign seq_pc = id_pc + XLEN'(PC_STEP);
    assign br_pc  = take ? seq_pc + {imm_se[XLEN-3:0], 2'b00} : seq_pc;

    // Branches and jumps always redirect, untaken ones back to PC+4
    assign redirect    = is_i | is_j;
    assign redirect_pc = is_j ? {id_instr.j_fmt.addr, 2'b00} : br_pc;
    assign squash      = redirect;       // One bubble behind every branch or jump

    always_ff @(posedge clk)
    begin
        if (rst || !is_r)                // I and J words do nothing further down
        begin
            ex_alu_op  <= ALU_PASS;
            ex_use_imm <= 1'b0;
            ex_wr_reg  <= 1'b0;
            ex_store   <= 1'b0;
            ex_wr_z    <= 1'b0;
            ex_wr_c    <= 1'b0;
            ex_wr_n    <= 1'b0;
        end
        else
        begin
            ex_alu_op  <= imm_load ? ALU_PASS
                                   : {id_instr.r_fmt.op[0], id_instr.r_fmt.funct[5:3]};
            ex_use_imm <= imm_load;
            ex_wr_reg  <= id_instr.r_fmt.op[2];                           // Bit 28
            ex_store   <= id_instr.r_fmt.op[3] & ~id_instr.r_fmt.op[2];   // Bit 29 only
            ex_wr_z    <= id_instr.r_fmt.funct[0];
            ex_wr_c    <= id_instr.r_fmt.funct[1];
            ex_wr_n    <= id_instr.r_fmt.funct[2];
        end
    end

endmodule

`default_nettype wire

//--- src/zmips_regfile.sv
// Register file, 32 words
// Two combinational read ports, one write port
// Write-through bypass so WB data reaches decode in the same cycle
`default_nettype none

module zmips_regfile import zmips_pkg::*;
(
    input  logic              clk,
    input  logic [REG_AW-1:0] rs_addr,
    input  logic [REG_AW-1:0] rt_addr,
    input  logic [REG_AW-1:0] wr_addr,
    input  logic [XLEN-1:0]   wr_data,
    input  logic              wr,
    output logic [XLEN-1:0]   rs_data,
    output logic [XLEN-1:0]   rt_data
);

    logic [XLEN-1:0] regs [NUM_REGS];   // Register 0 is an ordinary register

    always_ff @(posedge clk)
    begin
        if (wr)
        begin
            regs[wr_addr] <= wr_data;
        end
    end

    // Same-address read returns the value being written
    assign rs_data = (wr && wr_addr == rs_addr) ? wr_data : regs[rs_addr];
    assign rt_data = (wr && wr_addr == rt_addr) ? wr_data : regs[rt_addr];

endmodule

`default_nettype wire

//--- src/zmips_alu.sv
// ALU for the execute stage
// Logic ops, add and subtract with carry-in, barrel shifter on a
// Zero and carry-out outputs
`default_nettype none

module zmips_alu import zmips_pkg::*;
(
    input  logic [XLEN-1:0]   a,
    input  logic [XLEN-1:0]   b,
    input  alu_op_t           op,
    input  logic [REG_AW-1:0] shamt,
    input  logic              cin,
    output logic [XLEN-1:0]   y,
    output logic              zero,
    output logic              cout
);

    logic            is_sub;
    logic [XLEN-1:0] b_eff;
    logic [XLEN:0]   sum;          // Extra bit holds the carry-out

    // Subtract is a + ~b + cin, so carry out is an inverted borrow
    assign is_sub = (op == ALU_SUB);
    assign b_eff  = is_sub ? ~b : b;
    assign sum    = {1'b0, a} + {1'b0, b_eff} + {{XLEN{1'b0}}, cin};

    always_comb
    begin
        case (op)
            ALU_PASS: y = a;
            ALU_AND:  y = a & b;
            ALU_OR:   y = a | b;
            ALU_XOR:  y = a ^ b;
            ALU_ADD,
            ALU_SUB:  y = sum[XLEN-1:0];
            ALU_SLL:  y = a << shamt;
            ALU_SRL:  y = a >> shamt;
            ALU_SRA:  y = $signed(a) >>> shamt;     // Sign bit fills from the left
            default:  y = a;                        // Unused codes pass a
        endcase
    end

    assign zero = (y == '0);
    assign cout = (op == ALU_ADD || is_sub) ? sum[XLEN] : 1'b0;    // Only adder ops carry

endmodule

`default_nettype wire

//--- src/zmips_execute.sv
// Execute, memory and write-back stages
// ID/EX data register, operand forwarding from EX/MEM and MEM/WB
// Flag registers, EX/MEM register with the data port, MEM/WB register
`default_nettype none

module zmips_execute import zmips_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  instr_u            id_instr,
    input  logic [XLEN-1:0]   rs_data,
    input  logic [XLEN-1:0]   rt_data,
    input  alu_op_t           alu_op,       // Already registered in ID/EX
    input  logic              use_imm,
    input  logic              wr_reg,
    input  logic              store,
    input  logic              wr_z,
    input  logic              wr_c,
    input  logic              wr_n,
    output logic              flag_z,
    output logic              flag_c,
    output logic              flag_n,
    output logic              ex_z,
    output logic              ex_c,
    output logic              ex_n,
    output logic [REG_AW-1:0] wb_addr,
    output logic [XLEN-1:0]   wb_data,
    output logic              wb_wr,
    output logic [XLEN-1:0]   d_addr,
    output logic [XLEN-1:0]   d_wdata,
    output logic              d_wr
);

    logic [XLEN-1:0]   ex_rs_val, ex_rt_val, ex_imm;
    logic [REG_AW-1:0] ex_rs, ex_rt, ex_rd, ex_shamt;
    logic [XLEN-1:0]   alu_a, alu_b, alu_y;
    logic [REG_AW-1:0] ex_dest;
    logic              alu_cin;
    logic [XLEN-1:0]   mem_res, mem_data;   // EX/MEM payload
    logic [REG_AW-1:0] mem_dest;
    logic              mem_wr, mem_store;

    // Newest producer wins, EX/MEM before MEM/WB
    function automatic logic [XLEN-1:0] fwd(input logic [REG_AW-1:0] idx,
                                            input logic [XLEN-1:0]   id_val);
        if (mem_wr && mem_dest == idx)
            return mem_res;
        else if (wb_wr && wb_addr == idx)
            return wb_data;
        return id_val;
    endfunction

    always_ff @(posedge clk)
    begin
        ex_rs_val <= rs_data;
        ex_rt_val <= rt_data;
        ex_rs     <= id_instr.r_fmt.rs;
        ex_rt     <= id_instr.r_fmt.rt;
        ex_rd     <= id_instr.r_fmt.rd;
        ex_shamt  <= id_instr.r_fmt.shamt;
        ex_imm    <= {{(XLEN-IMM_W){id_instr.i_fmt.imm[IMM_W-1]}}, id_instr.i_fmt.imm};
    end

    assign alu_a   = use_imm ? ex_imm : fwd(ex_rs, ex_rs_val);
    assign alu_b   = fwd(ex_rt, ex_rt_val);       // Also the store data
    assign ex_dest = use_imm ? '0 : ex_rd;        // Immediate load targets r0
    // Compare needs cin 1, everything else chains through C
    assign alu_cin = (alu_op == ALU_SUB && !wr_reg) ? 1'b1 : flag_c;

    zmips_alu u_alu (
        .a     (alu_a),
        .b     (alu_b),
        .op    (alu_op),
        .shamt (ex_shamt),
        .cin   (alu_cin),
        .y     (alu_y),
        .zero  (ex_z),
        .cout  (ex_c)
    );

    assign ex_n = alu_y[XLEN-1];

    // Flags, each with its own update enable
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            flag_z <= 1'b0;
            flag_c <= 1'b0;
            flag_n <= 1'b0;
        end
        else
        begin
            if (wr_z) flag_z <= ex_z;
            if (wr_c) flag_c <= ex_c;
            if (wr_n) flag_n <= ex_n;
        end
    end

    always_ff @(posedge clk)
    begin
        mem_res  <= alu_y;
        mem_data <= alu_b;
        mem_dest <= ex_dest;
        wb_data  <= mem_res;                // MEM/WB carries the ALU result
        wb_addr  <= mem_dest;
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            mem_wr    <= 1'b0;
            mem_store <= 1'b0;
            wb_wr     <= 1'b0;
        end
        else
        begin
            mem_wr    <= wr_reg;
            mem_store <= store;
            wb_wr     <= mem_wr;
        end
    end

    // Data port straight from EX/MEM, no handshake
    assign d_addr  = mem_res;
    assign d_wdata = mem_data;
    assign d_wr    = mem_store;

endmodule

`default_nettype wire

//--- src/zmips_top.sv
// zmips core top level
// Fetch, control, register file and execute stages
// Instruction port and store-only data port
`default_nettype none

module zmips_top import zmips_pkg::*;
(
    input  logic            clk,
    input  logic            rst,
    input  logic [XLEN-1:0] i_data,
    output logic [XLEN-1:0] i_addr,
    output logic [XLEN-1:0] d_addr,
    output logic [XLEN-1:0] d_wdata,
    output logic            d_wr
);

    instr_u            id_instr;
    logic [XLEN-1:0]   id_pc;
    logic              redirect, squash;
    logic [XLEN-1:0]   redirect_pc;
    logic [XLEN-1:0]   rs_data, rt_data;
    alu_op_t           ex_alu_op;
    logic              ex_use_imm, ex_wr_reg, ex_store;
    logic              ex_wr_z, ex_wr_c, ex_wr_n;
    logic              flag_z, flag_c, flag_n;
    logic              ex_z, ex_c, ex_n;         // Flags forwarded to the branch
    logic [REG_AW-1:0] wb_addr;
    logic [XLEN-1:0]   wb_data;
    logic              wb_wr;

    zmips_fetch u_fetch (
        .clk, .rst, .redirect, .redirect_pc, .squash,
        .i_data, .i_addr, .id_instr, .id_pc
    );

    zmips_control u_control (
        .clk, .rst, .id_instr, .id_pc,
        .flag_z, .flag_c, .flag_n, .ex_z, .ex_c, .ex_n,
        .redirect, .redirect_pc, .squash,
        .ex_alu_op, .ex_use_imm, .ex_wr_reg, .ex_store,
        .ex_wr_z, .ex_wr_c, .ex_wr_n
    );

    zmips_regfile u_regfile (
        .clk,
        .rs_addr (id_instr.r_fmt.rs),
        .rt_addr (id_instr.r_fmt.rt),
        .wr_addr (wb_addr),
        .wr_data (wb_data),
        .wr      (wb_wr),
        .rs_data, .rt_data
    );

    zmips_execute u_execute (
        .clk, .rst, .id_instr, .rs_data, .rt_data,
        .alu_op (ex_alu_op), .use_imm (ex_use_imm), .wr_reg (ex_wr_reg),
        .store (ex_store), .wr_z (ex_wr_z), .wr_c (ex_wr_c), .wr_n (ex_wr_n),
        .flag_z, .flag_c, .flag_n, .ex_z, .ex_c, .ex_n,
        .wb_addr, .wb_data, .wb_wr, .d_addr, .d_wdata, .d_wr
    );

endmodule

`default_nettype wire

//--- verif/zmips_props.sv
// Concurrent assertions bound into zmips_top
// Reset release behaviour of the fetch address and the store strobe
// Word alignment of the fetch address
`default_nettype none

module zmips_props import zmips_pkg::*;
(
    input logic            clk,
    input logic            rst,
    input logic [XLEN-1:0] i_addr,
    input logic            d_wr
);
    timeunit 1ns;
    timeprecision 100ps;

    // First fetch at 0, then one word further
    reset_fetch: assert property (@(posedge clk) $fell(rst) |-> i_addr == '0 ##1 i_addr == 32'd4)
        else $error("Fetch address after reset release is wrong");

    // Nothing reaches the data port until the pipeline has filled
    reset_store: assert property (@(posedge clk) $fell(rst) |-> !d_wr ##1 !d_wr ##1 !d_wr)
        else $error("Store strobe active too early after reset release");

    word_align: assert property (@(posedge clk) disable iff (rst) i_addr[1:0] == 2'b00)
        else $error("Fetch address is not word aligned");

endmodule

bind zmips_top zmips_props u_props (.clk, .rst, .i_addr, .d_wr);

`default_nettype wire

//--- verif/tb_zmips.sv
// Testbench for the zmips core
// Clock, reset, instruction ROM with a fixed program
// Sequential ISA model that predicts the store stream
// Store checking on the data port and a watchdog
`default_nettype none

module tb_zmips import zmips_pkg::*; ();
    timeunit 1ns;
    timeprecision 100ps;

    logic            clk = 1'b0;
    logic            rst;
    logic [XLEN-1:0] i_data, i_addr, d_addr, d_wdata;
    logic            d_wr;
    logic [31:0]     rom [256];
    logic [31:0]     exp_addr_q [$];
    logic [31:0]     exp_data_q [$];
    logic [31:0]     seed = 32'd60447;
    logic [31:0]     halt_pc;
    int              plen = 0;
    int              errors = 0;
    int              stores = 0;

    always #50 clk = ~clk;

    zmips_top UUT (.clk, .rst, .i_data, .i_addr, .d_addr, .d_wdata, .d_wr);

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    // Instruction encoders
    function automatic logic [31:0] alu_word(input logic [3:0] code, input logic [4:0] rd,
                                             input logic [4:0] rs, input logic [4:0] rt,
                                             input logic [4:0] shamt);
        return {4'b0001, 1'b0, code[3], rs, rt, rd, shamt, code[2:0], 3'b000};
    endfunction

    function automatic logic [31:0] cmp_word(input logic [4:0] rs, input logic [4:0] rt);
        return {6'b000000, rs, rt, 10'd0, 3'b101, 3'b111};   // SUB, no write, all flags
    endfunction

    function automatic logic [31:0] store_word(input logic [4:0] rs, input logic [4:0] rt);
        return {6'b001000, rs, rt, 16'd0};
    endfunction

    function automatic logic [31:0] branch_word(input logic sense, input logic [1:0] cc,
                                                input logic [25:0] off);
        return {2'b10, sense, 1'b0, cc, off};
    endfunction

    task automatic put(input logic [31:0] w);
        rom[plen] = w;
        plen++;
    endtask

    // Immediate load to r0, then copy into rk
    task automatic load_reg(input logic [4:0] k, input logic [25:0] imm);
        put({4'b0101, 2'b00, imm});
        put(alu_word(ALU_PASS, k, 5'd0, 5'd0, 5'd0));
    endtask

    task automatic build_program();
        logic [4:0] sh [4];
        logic [4:0] ops [3];
        sh = '{5'd1, 5'd4, 5'd13, 5'd31};
        ops = '{5'd8, 5'd10, 5'd11};
        foreach (rom[i]) rom[i] = NOP_WORD;
        seed = lcg_next(seed);
        load_reg(5'd1, seed[25:0] & 26'h1ff_ffff);           // Positive operand
        seed = lcg_next(seed);
        load_reg(5'd2, seed[25:0]);
        seed = lcg_next(seed);
        load_reg(5'd3, seed[25:0] | 26'h200_0000);           // Negative operand
        load_reg(5'd20, 26'h100);                            // Store address
        // Back-to-back dependent ops, each stored at once
        put(alu_word(ALU_AND, 5'd4, 5'd1, 5'd2, 5'd0));
        put(store_word(5'd20, 5'd4));
        put(alu_word(ALU_OR, 5'd5, 5'd4, 5'd3, 5'd0));
        put(store_word(5'd20, 5'd5));
        put(alu_word(ALU_XOR, 5'd6, 5'd5, 5'd1, 5'd0));
        put(alu_word(ALU_ADD, 5'd7, 5'd6, 5'd2, 5'd0));
        put(alu_word(ALU_SUB, 5'd8, 5'd7, 5'd1, 5'd0));
        put(store_word(5'd20, 5'd6));
        put(store_word(5'd20, 5'd8));
        put(alu_word(ALU_ADD, 5'd9, 5'd1, 5'd2, 5'd0));
        put(NOP_WORD);                                       // Gap of one
        put(store_word(5'd20, 5'd9));
        foreach (sh[s])
            foreach (ops[o])
            begin
                put(alu_word({1'b1, ops[o][2:0]}, 5'd10, 5'd1, 5'd0, sh[s]));
                put(store_word(5'd20, 5'd10));
                put(alu_word({1'b1, ops[o][2:0]}, 5'd11, 5'd3, 5'd0, sh[s]));
                put(store_word(5'd20, 5'd11));
            end
        // Each compare is followed by every branch kind, taken ones skip a store
        for (int c = 0; c < 3; c++)
        begin
            if (c == 2)
                put(cmp_word(5'd3, 5'd1));                   // Negative result sets N
            else
                put(cmp_word(5'd1, c == 0 ? 5'd1 : 5'd3));
            for (int k = 0; k < 7; k++)
            begin
                put(branch_word(k[0], k[2:1], 26'd1));
                put(store_word(5'd20, 5'd4));
                put(store_word(5'd20, 5'd5));
            end
        end
        put({2'b11, 30'(plen + 2)});                         // Jump over one store
        put(store_word(5'd20, 5'd6));
        put(store_word(5'd20, 5'd7));
        seed = lcg_next(seed);
        put({4'b0101, 2'b00, seed[25:0]});
        put(store_word(5'd20, 5'd0));                        // r0 straight after load
        put({2'b11, 30'(plen)});                             // Halt loop
    endtask

    // Runs the program one instruction at a time and queues the stores
    task automatic run_model();
        logic [31:0] regs [32];
        logic [31:0] pc, w, a, b, y, sx;
        logic [32:0] sum;
        logic [3:0]  code;
        logic        z, c, n, fsel, cin, cout;
        pc = '0;
        z = 1'b0;
        c = 1'b0;
        n = 1'b0;
        foreach (regs[i]) regs[i] = '0;
        for (int steps = 0; steps < 10000; steps++)
        begin
            w  = rom[pc[9:2]];
            sx = {{6{w[25]}}, w[25:0]};
            if (w[31:30] == 2'b11)
            begin
                if ({w[29:0], 2'b00} == pc)
                    break;
                pc = {w[29:0], 2'b00};
            end
            else if (w[31:30] == 2'b10)
            begin
                case (w[27:26])
                    2'd0:    fsel = z;
                    2'd1:    fsel = c;
                    2'd2:    fsel = n;
                    default: fsel = w[29];                   // Always taken
                endcase
                pc = pc + 32'd4 + (fsel == w[29] ? {sx[29:0], 2'b00} : 32'd0);
            end
            else
            begin
                code = w[30] ? ALU_PASS : {w[26], w[5:3]};
                a    = w[30] ? sx : regs[w[25:21]];
                b    = regs[w[20:16]];
                cin  = (code == ALU_SUB && !w[28]) ? 1'b1 : c;
                sum  = {1'b0, a} + {1'b0, code == ALU_SUB ? ~b : b} + {32'd0, cin};
                cout = (code == ALU_ADD || code == ALU_SUB) ? sum[32] : 1'b0;
                case (code)
                    ALU_AND: y = a & b;
                    ALU_OR:  y = a | b;
                    ALU_XOR: y = a ^ b;
                    ALU_ADD, ALU_SUB: y = sum[31:0];
                    ALU_SLL: y = a << w[10:6];
                    ALU_SRL: y = a >> w[10:6];
                    ALU_SRA: y = $signed(a) >>> w[10:6];
                    default: y = a;
                endcase
                if (w[29] && !w[28])
                begin
                    exp_addr_q.push_back(y);
                    exp_data_q.push_back(b);
                end
                if (w[28]) regs[w[30] ? 5'd0 : w[15:11]] = y;
                if (w[0]) z = (y == '0);
                if (w[1]) c = cout;
                if (w[2]) n = y[31];
                pc = pc + 32'd4;
            end
        end
        halt_pc = pc;
    endtask

    task automatic check_store();
        logic [31:0] ea, ed;
        stores++;
        if (exp_addr_q.size() == 0)
        begin
            errors++;
            $display("Store to %h happened after the model ran out of stores", d_addr);
        end
        else
        begin
            ea = exp_addr_q.pop_front();
            ed = exp_data_q.pop_front();
            assert (d_addr == ea)
            else
            begin
                errors++;
                $display("Mismatch d_addr: got %h, expected %h", d_addr, ea);
            end
            assert (d_wdata == ed)
            else
            begin
                errors++;
                $display("Mismatch d_wdata: got %h, expected %h", d_wdata, ed);
            end
        end
    endtask

    // Outputs are settled mid-cycle, ROM data follows the new address
    always @(negedge clk)
    begin
        if (!rst && d_wr) check_store();
        i_data = rom[i_addr[9:2]];
    end

    initial
    begin
        rst    = 1'b1;
        i_data = NOP_WORD;
        build_program();
        run_model();
        repeat (2) @(negedge clk);
        rst = 1'b0;
        while (!(exp_addr_q.size() == 0 && i_addr == halt_pc)) @(negedge clk);
        repeat (4) @(negedge clk);                           // Drain EX, MEM, WB
        $display("Stores checked: %0d, errors: %0d", stores, errors);
        if (errors == 0)
            $display("Regression passed");
        else
            $display("Regression failed");
        $finish;
    end

    initial
    begin
        wait (plen != 0);
        repeat (plen * 3 + 50) @(posedge clk);
        $display("Test timed out before the program reached its halt loop");
        $display("Regression failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- zmips.f
src/zmips_pkg.sv
src/zmips_fetch.sv
src/zmips_control.sv
src/zmips_regfile.sv
src/zmips_alu.sv
src/zmips_execute.sv
src/zmips_top.sv
verif/zmips_props.sv
verif/tb_zmips.sv

//--- run_sim.sh
#!/bin/bash
# Build the zmips testbench with Verilator, run it, and check the log

rm -rf obj_dir sim.log

verilator --binary --timing --assert -j 0 --top-module tb_zmips -f zmips.f -o sim_zmips \
    && ./obj_dir/sim_zmips | tee sim.log \
    || echo "Build or simulation error"

grep -q "^Regression passed$" sim.log && echo "Result: PASS" || { echo "Result: FAIL"; exit 1; }
